// File: hdl/ooo_params.svh
// sizes for the out-of-order back end
// shared by the RTL and the testbench
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// datapath width
`define OOO_XLEN         32

// reorder buffer depth and tag width
`define OOO_ROB_SIZE     8
`define OOO_ROB_IDX_LEN  3

// execution units and multiply cycles
`define OOO_NUM_UNITS    3
`define OOO_MUL_LATENCY  6

// register that never takes a result
`define OOO_ZERO_REG     0
`endif

// File: hdl/ooo_pkg.sv
// types for the out-of-order back end
// opcodes, unit states and the packed buses between blocks
`include "ooo_params.svh"

package ooo_pkg;

    typedef enum logic [2:0] {ADD, SUB, AND, XOR, MUL, BEQ, BNE} opcode_e;

    typedef enum logic [1:0] {IDLE, BUSY, DONE} unit_state_e;

    // incoming instruction, operands already read
    typedef struct packed {
        logic [`OOO_XLEN-1:0]        pc;
        opcode_e                     opcode;
        logic [4:0]                  dest_reg;
        logic [`OOO_XLEN-1:0]        src_a;
        logic [`OOO_XLEN-1:0]        src_b;
        logic [`OOO_XLEN-1:0]        imm;
        logic                        pred_taken;
    } inst_t;

    // dispatch to an execution unit
    typedef struct packed {
        logic [`OOO_XLEN-1:0]        pc;
        opcode_e                     opcode;
        logic [`OOO_XLEN-1:0]        src_a;
        logic [`OOO_XLEN-1:0]        src_b;
        logic [`OOO_XLEN-1:0]        imm;
        logic                        pred_taken;
        logic [`OOO_ROB_IDX_LEN-1:0] tag;
    } issue_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] dest_reg;
        logic       pred_taken;
        logic       is_branch;
    } alloc_t;

    // finished result, value is next pc for a branch
    typedef struct packed {
        logic                        valid;
        logic [`OOO_ROB_IDX_LEN-1:0] tag;
        logic [`OOO_XLEN-1:0]        value;
        logic                        taken;
    } cdb_t;

    typedef struct packed {
        logic                 dest_valid;
        logic [4:0]           dest_reg;
        logic [`OOO_XLEN-1:0] value;
        logic                 is_branch;
    } retire_t;

    // one reorder buffer slot
    typedef struct packed {
        logic                 valid;
        logic                 ready;
        logic [4:0]           dest_reg;
        logic [`OOO_XLEN-1:0] value;
        logic                 pred_taken;
        logic                 is_branch;
        logic                 mis_pred;
    } rob_entry_t;

endpackage

// File: hdl/dispatch.sv
// dispatch stage
// allocates a reorder buffer tag and sends the instruction to a free unit
`include "ooo_params.svh"

module dispatch (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        squash,
    input  logic                        in_valid,
    input  ooo_pkg::inst_t              in_inst,
    output logic                        in_ready,
    input  logic                        full,
    input  logic [`OOO_ROB_IDX_LEN-1:0] tail,
    input  logic [`OOO_NUM_UNITS-1:0]   idle,
    output ooo_pkg::issue_t             issue,
    output logic [`OOO_NUM_UNITS-1:0]   issue_valid,
    output ooo_pkg::alloc_t             alloc
);
    logic                          fire;
    logic                          is_branch;
    logic [`OOO_NUM_UNITS-1:0]     unit_sel;

    // accept only with room in the rob and a free unit
    assign in_ready  = !full && (|idle) && !squash;
    assign fire      = in_valid && in_ready;
    assign is_branch = (in_inst.opcode == ooo_pkg::BEQ) || (in_inst.opcode == ooo_pkg::BNE);

    // one-hot lowest set bit of idle
    assign unit_sel    = idle & (~idle + 1'b1);
    assign issue_valid = fire ? unit_sel : '0;

    ////////////////////
    // issue packet tagged with the rob tail
    assign issue.pc         = in_inst.pc;
    assign issue.opcode     = in_inst.opcode;
    assign issue.src_a      = in_inst.src_a;
    assign issue.src_b      = in_inst.src_b;
    assign issue.imm        = in_inst.imm;
    assign issue.pred_taken = in_inst.pred_taken;
    assign issue.tag        = tail;

    // rob slot at tail
    assign alloc.valid      = fire;
    assign alloc.dest_reg   = in_inst.dest_reg;
    assign alloc.pred_taken = in_inst.pred_taken;
    assign alloc.is_branch  = is_branch;

endmodule

// File: hdl/exec_unit.sv
// execution unit
// alu, multiply and branch resolve, result held until the cdb takes it
`include "ooo_params.svh"

module exec_unit (
    input  logic            clock,
    input  logic            reset,
    input  logic            squash,
    input  ooo_pkg::issue_t issue,
    input  logic            issue_valid,
    output logic            idle,
    output ooo_pkg::cdb_t   result,
    input  logic            grant
);
    ooo_pkg::unit_state_e        state;
    logic [3:0]                  lat_count;
    logic [`OOO_XLEN-1:0]        alu_value;
    logic                        branch_taken;
    logic [`OOO_ROB_IDX_LEN-1:0] res_tag;
    logic [`OOO_XLEN-1:0]        res_value;
    logic                        res_taken;

    ////////////////////
    // operation on the incoming packet
    always_comb begin
        branch_taken = 1'b0;
        case (issue.opcode)
            ooo_pkg::ADD: alu_value = issue.src_a + issue.src_b;
            ooo_pkg::SUB: alu_value = issue.src_a - issue.src_b;
            ooo_pkg::AND: alu_value = issue.src_a & issue.src_b;
            ooo_pkg::XOR: alu_value = issue.src_a ^ issue.src_b;
            // low half of the product
            ooo_pkg::MUL: alu_value = issue.src_a * issue.src_b;
            ooo_pkg::BEQ, ooo_pkg::BNE: begin
                branch_taken = (issue.opcode == ooo_pkg::BEQ) ? (issue.src_a == issue.src_b)
                                                              : (issue.src_a != issue.src_b);
                // resolved next pc
                alu_value = branch_taken ? (issue.pc + issue.imm) : (issue.pc + `OOO_XLEN'(4));
            end
            default: alu_value = '0;
        endcase
    end

    ////////////////////
    // state machine, mul waits out its latency in BUSY
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            state     <= ooo_pkg::IDLE;
            lat_count <= '0;
        end else begin
            case (state)
                ooo_pkg::IDLE: begin
                    if (issue_valid && (issue.opcode == ooo_pkg::MUL)) begin
                        state     <= ooo_pkg::BUSY;
                        lat_count <= 4'(`OOO_MUL_LATENCY - 2);
                    end else if (issue_valid) begin
                        state <= ooo_pkg::DONE;
                    end
                end
                ooo_pkg::BUSY: begin
                    if (lat_count == '0) begin
                        state <= ooo_pkg::DONE;
                    end else begin
                        lat_count <= lat_count - 4'd1;
                    end
                end
                // hold until granted
                ooo_pkg::DONE: if (grant) state <= ooo_pkg::IDLE;
                default: state <= ooo_pkg::IDLE;
            endcase
        end
    end

    // result captured at issue
    always_ff @(posedge clock) begin
        if ((state == ooo_pkg::IDLE) && issue_valid) begin
            res_tag   <= issue.tag;
            res_value <= alu_value;
            res_taken <= branch_taken;
        end
    end

    assign idle         = (state == ooo_pkg::IDLE);
    assign result.valid = (state == ooo_pkg::DONE);
    assign result.tag   = res_tag;
    assign result.value = res_value;
    assign result.taken = res_taken;

endmodule

// File: hdl/cdb_arbiter.sv
// common data bus arbiter
// round-robin over finished units, one result per cycle onto a registered bus
`include "ooo_params.svh"

module cdb_arbiter (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    squash,
    input  ooo_pkg::cdb_t [`OOO_NUM_UNITS-1:0]      result,
    output logic [`OOO_NUM_UNITS-1:0]               grant,
    output ooo_pkg::cdb_t                           cdb
);
    logic [$clog2(`OOO_NUM_UNITS)-1:0] rr_ptr;
    logic [$clog2(`OOO_NUM_UNITS)-1:0] grant_idx;
    logic                              any_grant;

    // first holder at or after the pointer
    always_comb begin
        int idx;
        grant     = '0;
        grant_idx = '0;
        any_grant = 1'b0;
        for (int i = 0; i < `OOO_NUM_UNITS; i++) begin
            idx = int'(rr_ptr) + i;
            if (idx >= `OOO_NUM_UNITS) idx = idx - `OOO_NUM_UNITS;
            if (!any_grant && result[idx].valid) begin
                any_grant = 1'b1;
                grant_idx = idx[$clog2(`OOO_NUM_UNITS)-1:0];
            end
        end
        if (any_grant) grant[grant_idx] = 1'b1;
    end

    ////////////////////
    // pointer moves past the winner
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            rr_ptr    <= '0;
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= any_grant;
            if (any_grant) begin
                rr_ptr <= (grant_idx == `OOO_NUM_UNITS - 1) ? '0 : grant_idx + 1'b1;
            end
        end
    end

    // bus payload
    always_ff @(posedge clock) begin
        cdb.tag   <= result[grant_idx].tag;
        cdb.value <= result[grant_idx].value;
        cdb.taken <= result[grant_idx].taken;
    end

endmodule

// File: hdl/rob.sv
// reorder buffer
// circular, retires in program order, flushes on a mispredicted branch
`include "ooo_params.svh"

module rob (
    input  logic                        clock,
    input  logic                        reset,
    input  ooo_pkg::alloc_t             alloc,
    input  ooo_pkg::cdb_t               cdb,
    output logic                        full,
    output logic [`OOO_ROB_IDX_LEN-1:0] tail,
    output logic                        retire_valid,
    output ooo_pkg::retire_t            retire,
    output logic                        squash,
    output logic [`OOO_XLEN-1:0]        redirect_pc
);
    logic [`OOO_ROB_IDX_LEN-1:0]                 head;
    logic [`OOO_ROB_IDX_LEN:0]                   count;
    logic                                        empty;
    ooo_pkg::rob_entry_t [`OOO_ROB_SIZE-1:0]     entries;
    ooo_pkg::rob_entry_t                         head_entry;

    assign head_entry = entries[head];
    assign empty      = (count == '0);
    assign full       = (count == (`OOO_ROB_IDX_LEN + 1)'(`OOO_ROB_SIZE));

    ////////////////////
    // retirement from the head
    assign retire_valid = !empty && head_entry.ready;
    assign squash       = retire_valid && head_entry.mis_pred;
    // branch value holds the resolved next pc
    assign redirect_pc  = head_entry.value;

    assign retire.dest_valid = (head_entry.dest_reg != 5'(`OOO_ZERO_REG));
    assign retire.dest_reg   = head_entry.dest_reg;
    assign retire.value      = head_entry.value;
    assign retire.is_branch  = head_entry.is_branch;

    ////////////////////
    // pointers and entry control
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            // squash drops the head and everything younger
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < `OOO_ROB_SIZE; i++) begin
                entries[i].valid    <= 1'b0;
                entries[i].ready    <= 1'b0;
                entries[i].mis_pred <= 1'b0;
            end
        end else begin
            // new slot at tail
            if (alloc.valid) begin
                entries[tail].valid      <= 1'b1;
                entries[tail].ready      <= 1'b0;
                entries[tail].mis_pred   <= 1'b0;
                entries[tail].dest_reg   <= alloc.dest_reg;
                entries[tail].pred_taken <= alloc.pred_taken;
                entries[tail].is_branch  <= alloc.is_branch;
                tail                     <= tail + 1'b1;
            end
            // writeback, only into a live slot
            if (cdb.valid && entries[cdb.tag].valid) begin
                entries[cdb.tag].ready    <= 1'b1;
                entries[cdb.tag].value    <= cdb.value;
                entries[cdb.tag].mis_pred <= entries[cdb.tag].is_branch &&
                                             (cdb.taken != entries[cdb.tag].pred_taken);
            end
            if (retire_valid) begin
                entries[head].valid <= 1'b0;
                entries[head].ready <= 1'b0;
                head                <= head + 1'b1;
            end
            // occupancy
            case ({alloc.valid, retire_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hdl/ooo_core.sv
// out-of-order back end top level
// dispatch, execution units, cdb arbiter and reorder buffer
`include "ooo_params.svh"

module ooo_core (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 in_valid,
    input  ooo_pkg::inst_t       in_inst,
    output logic                 in_ready,
    output logic                 retire_valid,
    output ooo_pkg::retire_t     retire,
    output logic                 squash,
    output logic [`OOO_XLEN-1:0] redirect_pc
);
    logic                                   full;
    logic [`OOO_ROB_IDX_LEN-1:0]            tail;
    logic [`OOO_NUM_UNITS-1:0]              idle;
    logic [`OOO_NUM_UNITS-1:0]              issue_valid;
    logic [`OOO_NUM_UNITS-1:0]              grant;
    ooo_pkg::issue_t                        issue;
    ooo_pkg::alloc_t                        alloc;
    ooo_pkg::cdb_t [`OOO_NUM_UNITS-1:0]     result;
    ooo_pkg::cdb_t                          cdb;

    dispatch i_dispatch (
        .clock(clock), .reset(reset), .squash(squash),
        .in_valid(in_valid), .in_inst(in_inst), .in_ready(in_ready),
        .full(full), .tail(tail),
        .idle(idle), .issue(issue), .issue_valid(issue_valid),
        .alloc(alloc)
    );

    ////////////////////
    // identical units, shared issue bus
    for (genvar k = 0; k < `OOO_NUM_UNITS; k++) begin : g_unit
        exec_unit i_exec_unit (
            .clock(clock), .reset(reset), .squash(squash),
            .issue(issue), .issue_valid(issue_valid[k]),
            .idle(idle[k]),
            .result(result[k]), .grant(grant[k])
        );
    end

    cdb_arbiter i_cdb_arbiter (
        .clock(clock), .reset(reset), .squash(squash),
        .result(result), .grant(grant), .cdb(cdb)
    );

    rob i_rob (
        .clock(clock), .reset(reset),
        .alloc(alloc), .cdb(cdb),
        .full(full), .tail(tail),
        .retire_valid(retire_valid), .retire(retire),
        .squash(squash), .redirect_pc(redirect_pc)
    );

endmodule

// File: verif/ooo_core_asserts.sv
// protocol checks on the ooo_core ports
// bound into the top level
module ooo_core_asserts (
    input logic clock,
    input logic reset,
    input logic in_ready,
    input logic retire_valid,
    input logic squash
);
    timeunit 1ns;
    timeprecision 100ps;

    ////////////////////
    // quiet out of reset
    a_reset_quiet: assert property (@(posedge clock)
        reset |=> (!retire_valid && !squash))
        else $error("retire_valid or squash high during reset");

    // squash only on a retiring head
    a_squash_retires: assert property (@(posedge clock) disable iff (reset)
        squash |-> retire_valid)
        else $error("squash without retire_valid");

    // buffer flushed, nothing left to retire
    a_flush_gap: assert property (@(posedge clock) disable iff (reset)
        squash |=> !retire_valid)
        else $error("retire_valid high right after squash");

    // input stalls while flushing
    a_no_accept_on_squash: assert property (@(posedge clock) disable iff (reset)
        squash |-> !in_ready)
        else $error("in_ready high during squash");

endmodule

bind ooo_core ooo_core_asserts i_ooo_core_asserts (
    .clock(clock),
    .reset(reset),
    .in_ready(in_ready),
    .retire_valid(retire_valid),
    .squash(squash)
);

// File: verif/ooo_core_tb.sv
// testbench for the out-of-order back end
// in-order reference queue, retirement checked by immediate assertions
`include "ooo_params.svh"

module ooo_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DRAIN_LIMIT = 200;
    localparam int ACCEPT_LIMIT = 100;

    logic                 clock;
    logic                 reset;
    logic                 in_valid;
    ooo_pkg::inst_t       in_inst;
    logic                 in_ready;
    logic                 retire_valid;
    ooo_pkg::retire_t     retire;
    logic                 squash;
    logic [`OOO_XLEN-1:0] redirect_pc;

    ooo_pkg::retire_t     exp_retire[$];
    logic                 exp_squash[$];
    int                   outstanding;
    logic                 saw_stall;
    logic [`OOO_XLEN-1:0] next_pc;
    integer               seed;
    int unsigned          op_sel;

    ooo_core i_ooo_core (
        .clock(clock), .reset(reset),
        .in_valid(in_valid), .in_inst(in_inst), .in_ready(in_ready),
        .retire_valid(retire_valid), .retire(retire),
        .squash(squash), .redirect_pc(redirect_pc)
    );

    always #5 clock = ~clock;

    ////////////////////
    // failure reporting
    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_failed(input string msg);
        abort_run($sformatf("CHECK FAILED at %0d ns: %s", $time, msg));
    endtask

    ////////////////////
    // reference model
    function automatic logic resolve_taken(input ooo_pkg::inst_t inst);
        // beq on equal, bne on unequal
        if (inst.opcode == ooo_pkg::BEQ) return inst.src_a == inst.src_b;
        return inst.src_a != inst.src_b;
    endfunction

    function automatic logic is_mispredict(input ooo_pkg::inst_t inst);
        logic branch;
        branch = (inst.opcode == ooo_pkg::BEQ) || (inst.opcode == ooo_pkg::BNE);
        return branch && (resolve_taken(inst) != inst.pred_taken);
    endfunction

    function automatic ooo_pkg::retire_t expect_retire(input ooo_pkg::inst_t inst);
        ooo_pkg::retire_t        r;
        logic [2*`OOO_XLEN-1:0] product;
        product = {{`OOO_XLEN{1'b0}}, inst.src_a} * {{`OOO_XLEN{1'b0}}, inst.src_b};
        r.dest_reg   = inst.dest_reg;
        r.dest_valid = (inst.dest_reg != `OOO_ZERO_REG);
        r.is_branch  = 1'b0;
        case (inst.opcode)
            ooo_pkg::ADD: r.value = inst.src_a + inst.src_b;
            ooo_pkg::SUB: r.value = inst.src_a - inst.src_b;
            ooo_pkg::AND: r.value = inst.src_a & inst.src_b;
            ooo_pkg::XOR: r.value = inst.src_a ^ inst.src_b;
            ooo_pkg::MUL: r.value = product[`OOO_XLEN-1:0];
            default: begin
                // next pc of a resolved branch
                r.is_branch = 1'b1;
                r.value = resolve_taken(inst) ? inst.pc + inst.imm : inst.pc + 32'd4;
            end
        endcase
        return r;
    endfunction

    ////////////////////
    // stimulus tasks start 1 ns after a rising edge
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_retire.size() != 0) begin
            @(negedge clock);
            cycles++;
            if (cycles > DRAIN_LIMIT) abort_run("timeout: instructions did not retire");
        end
        @(posedge clock);
        #1;
    endtask

    task automatic send_op(input ooo_pkg::opcode_e op, input logic [4:0] dest,
                           input logic [`OOO_XLEN-1:0] a, input logic [`OOO_XLEN-1:0] b,
                           input logic [`OOO_XLEN-1:0] imm, input logic pred);
        ooo_pkg::inst_t inst;
        int             waited;
        logic           taken_now;
        inst = '{pc: next_pc, opcode: op, dest_reg: dest, src_a: a, src_b: b,
                 imm: imm, pred_taken: pred};
        next_pc  = next_pc + 32'd4;
        in_valid = 1'b1;
        in_inst  = inst;
        waited   = 0;
        taken_now = 1'b0;
        // in_ready is settled at the falling edge
        while (!taken_now) begin
            @(negedge clock);
            taken_now = in_ready;
            waited++;
            if (waited > ACCEPT_LIMIT) abort_run("timeout: instruction was never accepted");
        end
        @(posedge clock);
        #1;
        in_valid = 1'b0;
        // nothing younger goes in behind a mispredict
        if (is_mispredict(inst)) wait_drain();
    endtask

    task automatic send_random_alu(input int n);
        for (int i = 0; i < n; i++) begin
            op_sel = $unsigned($random(seed)) % 5;
            send_op(ooo_pkg::opcode_e'(op_sel[2:0]), 5'($random(seed)),
                    $random(seed), $random(seed), '0, 1'b0);
        end
    endtask

    ////////////////////
    // monitor samples outputs mid-cycle
    always @(negedge clock) begin
        if (!reset) begin
            if (in_valid && in_ready) begin
                exp_retire.push_back(expect_retire(in_inst));
                exp_squash.push_back(is_mispredict(in_inst));
                outstanding++;
            end
            if (in_valid && !in_ready) saw_stall = 1'b1;
            if (retire_valid) begin
                assert (exp_retire.size() != 0)
                    else check_failed("retirement with nothing outstanding");
                assert (retire == exp_retire[0])
                    else check_failed($sformatf("retire %h, expected %h", retire, exp_retire[0]));
                assert (squash == exp_squash[0])
                    else check_failed($sformatf("squash %b, expected %b", squash, exp_squash[0]));
                if (squash) begin
                    assert (redirect_pc == exp_retire[0].value)
                        else check_failed($sformatf("redirect_pc %h, expected %h",
                                                    redirect_pc, exp_retire[0].value));
                end
                void'(exp_retire.pop_front());
                void'(exp_squash.pop_front());
                outstanding--;
            end
            assert (outstanding <= `OOO_ROB_SIZE)
                else check_failed($sformatf("%0d instructions in flight", outstanding));
        end
    end

    initial begin
        seed        = 37142;
        clock       = 1'b0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_inst     = '0;
        outstanding = 0;
        saw_stall   = 1'b0;
        next_pc     = 32'h0000_1000;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;

        // random alu mix, then a slow mul ahead of quick adds
        send_random_alu(12);
        send_op(ooo_pkg::MUL, 5'd7, 32'h0001_2345, 32'h0000_0678, '0, 1'b0);
        for (int i = 0; i < 3; i++) begin
            send_op(ooo_pkg::ADD, 5'(i + 1), $random(seed), 32'd9, '0, 1'b0);
        end
        // register zero is never written
        send_op(ooo_pkg::ADD, 5'd0, 32'd5, 32'd6, '0, 1'b0);
        wait_drain();

        // mul at the head while adds fill the buffer
        saw_stall = 1'b0;
        send_op(ooo_pkg::MUL, 5'd3, $random(seed), $random(seed), '0, 1'b0);
        for (int i = 0; i < 12; i++) begin
            send_op(ooo_pkg::ADD, 5'd4, $random(seed), 32'd1, '0, 1'b0);
        end
        assert (saw_stall) else check_failed("in_ready never went low during the burst");
        wait_drain();

        // correct predictions
        send_op(ooo_pkg::BEQ, 5'd0, 32'd8, 32'd8, 32'h40, 1'b1);
        send_op(ooo_pkg::BNE, 5'd0, 32'd8, 32'd9, 32'h80, 1'b1);
        send_op(ooo_pkg::BEQ, 5'd0, 32'd1, 32'd2, 32'h20, 1'b0);
        wait_drain();

        // mispredicts, then normal traffic after the flush
        send_op(ooo_pkg::ADD, 5'd2, 32'd3, 32'd4, '0, 1'b0);
        send_op(ooo_pkg::BNE, 5'd0, 32'd5, 32'd5, 32'h100, 1'b1);
        send_op(ooo_pkg::BEQ, 5'd0, 32'd6, 32'd6, 32'h200, 1'b0);
        send_random_alu(6);
        wait_drain();

        if (exp_retire.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            check_failed("expected retirements left over");
        end
    end

endmodule

// File: flist.f
+incdir+hdl
hdl/ooo_pkg.sv
hdl/dispatch.sv
hdl/exec_unit.sv
hdl/cdb_arbiter.sv
hdl/rob.sv
hdl/ooo_core.sv
verif/ooo_core_asserts.sv
verif/ooo_core_tb.sv

// File: Makefile
# Verilator build and run for the out-of-order back end

VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SOURCES   := $(shell grep -v '^+' $(FLIST)) hdl/ooo_params.svh
EXE       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(EXE)
	./$(EXE)

clean:
	rm -rf $(BUILD_DIR)
